/* sim.f */
rtl/ctrl_cfg_pkg.sv
rtl/ctrl_types_pkg.sv
rtl/ctrl_byte_fifo.sv
rtl/ctrl_cmd_dispatch.sv
rtl/ctrl_cmd_watchdog.sv
rtl/ctrl_cmd_regwrite.sv
rtl/ctrl_subsystem_top.sv
verification/ctrl_subsystem_sva.sv
verification/tb_ctrl_subsystem.sv

/* verification/tb_ctrl_subsystem.sv */
// --------------------------------------------------------------------------
// Directed testbench. The host model tracks credits and outputs are sampled
// on the falling clock edge.
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_ctrl_subsystem;

    localparam int TICKS = ctrl_cfg_pkg::WDOG_TICKS;
    localparam int DEPTH = ctrl_cfg_pkg::FIFO_DEPTH;
    // Reset, register writes, keep-alive, expiry, opcode and burst tests, then margin.
    localparam int RUN_CYCLES = 20 + 150 + 3 * TICKS + 2 * TICKS + 300 + 500;

    logic                       clk;
    logic                       reset;
    ctrl_types_pkg::link_byte_t link_in;
    logic                       credit_return;
    logic                       bad_cmd;
    logic                       sys_reset;
    ctrl_types_pkg::cfg_bank_t  cfg_regs;

    ctrl_types_pkg::cfg_bank_t  model_bank;
    logic [7:0] tx_q [$];
    int credits      = DEPTH;
    int credit_low   = DEPTH;
    int bytes_sent   = 0;
    int credits_back = 0;
    int bad_pulses   = 0;
    int cycle        = 0;
    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int test_errors;
    string test_name = "startup";

    ctrl_subsystem_top u_ctrl_subsystem_top (
        .clk           (clk),
        .reset         (reset),
        .link_in       (link_in),
        .credit_return (credit_return),
        .bad_cmd       (bad_cmd),
        .sys_reset     (sys_reset),
        .cfg_regs      (cfg_regs)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Each cycle with credit_return high gives the host one credit back.
    always @(negedge clk) begin
        if (!reset && credit_return) begin
            credits      = credits + 1;
            credits_back = credits_back + 1;
            if (credits > DEPTH) begin
                $display("** Error: [%s] host credits rose above the FIFO depth", test_name);
                errors = errors + 1;
            end
        end
        if (!reset && bad_cmd) begin
            bad_pulses = bad_pulses + 1;
        end
    end

    task automatic check_bank(input string what, input ctrl_types_pkg::cfg_bank_t exp,
                              input ctrl_types_pkg::cfg_bank_t act);
        if (act !== exp) begin
            $display("** Error: [%s] %s expected %h, actual %h", test_name, what, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: [%s] %s expected %b, actual %b", test_name, what, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic check_credits(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("** Error: [%s] %s expected %0d, actual %0d", test_name, what, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
        tests_run   = tests_run + 1;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("test %s: done, no errors", test_name);
        end else begin
            $display("test %s: done, %0d errors", test_name, errors - test_errors);
            tests_failed = tests_failed + 1;
        end
    endtask

    task automatic queue_write(input logic [7:0] addr, input logic [7:0] data);
        tx_q.push_back(ctrl_cfg_pkg::OP_REG_WRITE);
        tx_q.push_back(addr);
        tx_q.push_back(data);
        model_bank.regs[addr % ctrl_cfg_pkg::REG_COUNT] = data;
    endtask

    // The first payload byte is the most significant signature byte.
    task automatic queue_kick(input logic [ctrl_cfg_pkg::SIG_BITS-1:0] sig);
        tx_q.push_back(ctrl_cfg_pkg::OP_WDOG_KICK);
        for (int i = ctrl_cfg_pkg::SIG_BYTES - 1; i >= 0; i--) begin
            tx_q.push_back(sig[8*i +: 8]);
        end
    endtask

    // Sends the queued bytes back to back and holds off while no credit is left.
    task automatic send_burst();
        while (tx_q.size() > 0) begin
            @(posedge clk);
            while (credits == 0) begin
                link_in <= '0;
                @(posedge clk);
            end
            link_in <= '{valid: 1'b1, data: tx_q.pop_front()};
            credits    = credits - 1;
            bytes_sent = bytes_sent + 1;
            if (credits < credit_low) credit_low = credits;
        end
        @(posedge clk);
        link_in <= '0;
    endtask

    task automatic wait_drain();
        int n = 0;
        @(negedge clk);
        while (credits != DEPTH && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (credits != DEPTH) begin
            $display("** Error: [%s] the FIFO did not drain within 100 cycles", test_name);
            errors = errors + 1;
        end
        repeat (3) @(negedge clk);   // Beat and register update behind the last pop.
    endtask

    task automatic test_reset_state();
        begin_test("reset_state");
        @(negedge clk);
        check_bit("sys_reset", 1'b0, sys_reset);
        check_bit("bad_cmd", 1'b0, bad_cmd);
        check_bit("credit_return", 1'b0, credit_return);
        check_bank("cfg_regs", '0, cfg_regs);
        end_test();
    endtask

    task automatic test_reg_writes();
        begin_test("reg_writes");
        repeat (12) queue_write(8'($urandom), 8'($urandom));
        send_burst();
        wait_drain();
        check_bank("cfg_regs", model_bank, cfg_regs);
        end_test();
    endtask

    task automatic test_keepalive();
        logic seen_high = 1'b0;
        begin_test("keepalive");
        repeat (6) begin   // One kick every TICKS/2 cycles over 3*TICKS cycles.
            queue_kick(ctrl_cfg_pkg::SIG_PATTERN);
            send_burst();
            repeat (TICKS / 2 - ctrl_cfg_pkg::LEN_WDOG - 2) begin
                @(negedge clk);
                seen_high = seen_high | sys_reset;
            end
        end
        check_bit("sys_reset seen high", 1'b0, seen_high);
        end_test();
    endtask

    task automatic test_bad_signature();
        int good_cycle;
        int n = 0;
        begin_test("bad_signature");
        queue_kick(ctrl_cfg_pkg::SIG_PATTERN);
        send_burst();
        good_cycle = cycle;
        repeat (TICKS / 2) @(posedge clk);
        queue_kick(~ctrl_cfg_pkg::SIG_PATTERN);
        send_burst();
        while (!sys_reset && (cycle - good_cycle) < TICKS + 10) @(negedge clk);
        check_bit("sys_reset after expiry", 1'b1, sys_reset);
        queue_kick(ctrl_cfg_pkg::SIG_PATTERN);
        send_burst();
        while (sys_reset && n < 10) begin
            @(negedge clk);
            n++;
        end
        check_bit("sys_reset after good kick", 1'b0, sys_reset);
        end_test();
    endtask

    task automatic test_bad_opcode();
        int pulses_before;
        begin_test("bad_opcode");
        pulses_before = bad_pulses;
        tx_q.push_back(8'h77);
        queue_write(8'($urandom), 8'($urandom));
        send_burst();
        wait_drain();
        check_bit("bad_cmd pulse", 1'b1, bad_pulses == pulses_before + 1);
        check_bank("cfg_regs", model_bank, cfg_regs);
        end_test();
    endtask

    task automatic test_credit_burst();
        int sent_before;
        int back_before;
        begin_test("credit_burst");
        sent_before = bytes_sent;
        back_before = credits_back;
        credit_low  = credits;
        for (int i = 0; i < 4; i++) begin
            queue_write(8'($urandom), 8'($urandom));
            if (i % 2 == 0) queue_kick(ctrl_cfg_pkg::SIG_PATTERN);
        end
        tx_q.push_back(8'hE1);
        queue_write(8'($urandom), 8'($urandom));
        send_burst();
        wait_drain();
        check_credits("credits when idle", DEPTH, credits);
        check_credits("credit_return pulses", bytes_sent - sent_before,
                      credits_back - back_before);
        // Back to back, one byte is on the link and one sits in the FIFO.
        check_credits("lowest credit count", DEPTH - 2, credit_low);
        check_bank("cfg_regs", model_bank, cfg_regs);
        check_bit("sys_reset", 1'b0, sys_reset);
        end_test();
    endtask

    initial begin
        repeat (RUN_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", RUN_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h2f0c8d0a));
        link_in    = '0;
        reset      = 1'b1;
        model_bank = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_reset_state();
        test_reg_writes();
        test_keepalive();
        test_bad_signature();
        test_bad_opcode();
        test_credit_burst();
        if (u_ctrl_subsystem_top.u_ctrl_subsystem_sva.failures != 0) begin
            $display("** Error: the bound checker saw %0d assertion failures",
                     u_ctrl_subsystem_top.u_ctrl_subsystem_sva.failures);
            errors = errors + u_ctrl_subsystem_top.u_ctrl_subsystem_sva.failures;
        end
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/ctrl_subsystem_sva.sv */
// --------------------------------------------------------------------------
// Link and watchdog checks bound into the top level. The FIFO count and the
// watchdog match are reached through the bind port list.
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ctrl_subsystem_sva (
    input wire                                    clk,
    input wire                                    reset,
    input wire                                    link_valid,
    input wire                                    credit_return,
    input wire                                    sys_reset,
    input wire                                    kick_ok,
    input wire [ctrl_cfg_pkg::FIFO_CNT_BITS-1:0]  fifo_count
);

    int quiet_cycles;   // Cycles since the last matching signature, saturating.
    int held_bytes;     // Bytes sent by the host and not yet credited back.
    int failures = 0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            quiet_cycles <= 0;
        end else if (kick_ok) begin
            quiet_cycles <= 0;
        end else if (quiet_cycles <= ctrl_cfg_pkg::WDOG_TICKS) begin
            quiet_cycles <= quiet_cycles + 1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            held_bytes <= 0;
        end else begin
            held_bytes <= held_bytes + int'(link_valid) - int'(credit_return);
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        link_valid |-> (fifo_count != ctrl_cfg_pkg::FIFO_DEPTH))
        else begin
            failures = failures + 1;
            $error("A byte arrived while the FIFO was full.");
        end

    no_credit_when_empty: assert property (@(posedge clk) disable iff (reset)
        credit_return |-> (held_bytes != 0))
        else begin
            failures = failures + 1;
            $error("credit_return pulsed with no byte left to credit.");
        end

    late_sys_reset: assert property (@(posedge clk) disable iff (reset)
        $rose(sys_reset) |-> (quiet_cycles >= ctrl_cfg_pkg::WDOG_TICKS))
        else begin
            failures = failures + 1;
            $error("sys_reset rose before the watchdog period ran out.");
        end

endmodule

bind ctrl_subsystem_top ctrl_subsystem_sva u_ctrl_subsystem_sva (
    .clk           (clk),
    .reset         (reset),
    .link_valid    (link_in.valid),
    .credit_return (credit_return),
    .sys_reset     (sys_reset),
    .kick_ok       (u_ctrl_cmd_watchdog.kick_ok),
    .fifo_count    (u_ctrl_byte_fifo.count)
);

`default_nettype wire

/* rtl/ctrl_subsystem_top.sv */
// --------------------------------------------------------------------------
// Command front end top level. The host must obey the credit protocol.
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ctrl_subsystem_top (
    input  wire                        clk,
    input  wire                        reset,
    input  wire ctrl_types_pkg::link_byte_t link_in,
    output logic                       credit_return,
    output logic                       bad_cmd,
    output logic                       sys_reset,
    output ctrl_types_pkg::cfg_bank_t  cfg_regs
);

    logic [7:0]                pop_byte;
    logic                      pop_valid;
    ctrl_types_pkg::cmd_beat_t wdog_beat;
    ctrl_types_pkg::cmd_beat_t wr_beat;

    ctrl_byte_fifo u_ctrl_byte_fifo (
        .clk           (clk),
        .reset         (reset),
        .link_in       (link_in),
        .pop_byte      (pop_byte),
        .pop_valid     (pop_valid),
        .credit_return (credit_return)
    );

    ctrl_cmd_dispatch u_ctrl_cmd_dispatch (
        .clk       (clk),
        .reset     (reset),
        .pop_byte  (pop_byte),
        .pop_valid (pop_valid),
        .wdog_beat (wdog_beat),
        .wr_beat   (wr_beat),
        .bad_cmd   (bad_cmd)
    );

    ctrl_cmd_watchdog u_ctrl_cmd_watchdog (
        .clk       (clk),
        .reset     (reset),
        .beat      (wdog_beat),
        .sys_reset (sys_reset)
    );

    ctrl_cmd_regwrite u_ctrl_cmd_regwrite (
        .clk      (clk),
        .reset    (reset),
        .beat     (wr_beat),
        .cfg_regs (cfg_regs)
    );

endmodule

`default_nettype wire

/* rtl/ctrl_cmd_regwrite.sv */
// --------------------------------------------------------------------------
// Register-write handler. The address byte is taken modulo REG_COUNT and
// the bank has no readback path.
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ctrl_cmd_regwrite (
    input  wire                        clk,
    input  wire                        reset,
    input  wire ctrl_types_pkg::cmd_beat_t beat,
    output ctrl_types_pkg::cfg_bank_t  cfg_regs
);

    logic [ctrl_cfg_pkg::REG_ADDR_BITS-1:0] addr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            addr <= '0;
        end else if (beat.en && !beat.last) begin
            addr <= beat.data[ctrl_cfg_pkg::REG_ADDR_BITS-1:0];   // First payload byte.
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_regs <= '0;
        end else if (beat.en && beat.last) begin
            cfg_regs.regs[addr] <= beat.data;   // Data byte lands one cycle after it.
        end
    end

endmodule

`default_nettype wire

/* rtl/ctrl_cmd_watchdog.sv */
// --------------------------------------------------------------------------
// Signature-kicked watchdog. The command length comes from the beat's last
// flag, and sys_reset holds until a matching signature is received.
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ctrl_cmd_watchdog (
    input  wire                        clk,
    input  wire                        reset,
    input  wire ctrl_types_pkg::cmd_beat_t beat,
    output logic                       sys_reset
);

    logic [ctrl_cfg_pkg::SIG_BITS-1:0]  sig;
    logic [ctrl_cfg_pkg::SIG_BITS-1:0]  sig_next;
    logic [ctrl_cfg_pkg::TICK_BITS-1:0] ticks;
    logic kick_ok;

    // First payload byte ends up in the most significant position.
    assign sig_next = {sig[ctrl_cfg_pkg::SIG_BITS-9:0], beat.data};
    assign kick_ok  = beat.en && beat.last && (sig_next == ctrl_cfg_pkg::SIG_PATTERN);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sig <= '0;
        end else if (beat.en) begin
            if (beat.last) begin
                sig <= '0;   // Every command starts from a clean signature.
            end else begin
                sig <= sig_next;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ticks <= (ctrl_cfg_pkg::TICK_BITS)'(ctrl_cfg_pkg::WDOG_TICKS);
        end else if (kick_ok) begin
            ticks <= (ctrl_cfg_pkg::TICK_BITS)'(ctrl_cfg_pkg::WDOG_TICKS);
        end else if (ticks != '0) begin
            ticks <= ticks - 1'b1;
        end
    end

    // Expired counter shows up on sys_reset one cycle later.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sys_reset <= 1'b0;
        end else begin
            sys_reset <= (ticks == '0);
        end
    end

endmodule

`default_nettype wire

/* rtl/ctrl_cmd_dispatch.sv */
// --------------------------------------------------------------------------
// Opcode decoder and payload router. Payload lengths are fixed per opcode
// and an unknown opcode is dropped with a one-cycle bad_cmd pulse.
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ctrl_cmd_dispatch (
    input  wire                        clk,
    input  wire                        reset,
    input  wire [7:0]                  pop_byte,
    input  wire                        pop_valid,
    output ctrl_types_pkg::cmd_beat_t  wdog_beat,
    output ctrl_types_pkg::cmd_beat_t  wr_beat,
    output logic                       bad_cmd
);

    typedef enum logic {
        ST_IDLE,
        ST_PAYLOAD
    } state_t;

    typedef enum logic {
        TGT_WDOG,
        TGT_REG
    } target_t;

    state_t  state;
    target_t target;
    logic [ctrl_cfg_pkg::LEN_BITS-1:0] remain;
    logic last;

    assign last = (remain == 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ST_IDLE;
            target    <= TGT_WDOG;
            remain    <= '0;
            wdog_beat <= '0;
            wr_beat   <= '0;
            bad_cmd   <= 1'b0;
        end else begin
            wdog_beat.en <= 1'b0;   // Beats and bad_cmd are single-cycle pulses.
            wr_beat.en   <= 1'b0;
            bad_cmd      <= 1'b0;
            if (pop_valid) begin
                case (state)
                    ST_IDLE: begin
                        case (pop_byte)
                            ctrl_cfg_pkg::OP_WDOG_KICK: begin
                                remain <= (ctrl_cfg_pkg::LEN_BITS)'(ctrl_cfg_pkg::LEN_WDOG);
                                target <= TGT_WDOG;
                                state  <= ST_PAYLOAD;
                            end
                            ctrl_cfg_pkg::OP_REG_WRITE: begin
                                remain <= (ctrl_cfg_pkg::LEN_BITS)'(ctrl_cfg_pkg::LEN_REG_WRITE);
                                target <= TGT_REG;
                                state  <= ST_PAYLOAD;
                            end
                            default: bad_cmd <= 1'b1;
                        endcase
                    end
                    ST_PAYLOAD: begin
                        if (target == TGT_WDOG) begin
                            wdog_beat <= '{en: 1'b1, last: last, data: pop_byte};
                        end else begin
                            wr_beat <= '{en: 1'b1, last: last, data: pop_byte};
                        end
                        remain <= remain - 1'b1;
                        if (last) begin
                            state <= ST_IDLE;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ctrl_byte_fifo.sv */
// --------------------------------------------------------------------------
// Input byte FIFO. A write while full is dropped, since credits forbid it.
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ctrl_byte_fifo (
    input  wire                        clk,
    input  wire                        reset,
    input  wire ctrl_types_pkg::link_byte_t link_in,
    output logic [7:0]                 pop_byte,
    output logic                       pop_valid,
    output logic                       credit_return
);

    logic [7:0] mem [ctrl_cfg_pkg::FIFO_DEPTH];
    logic [ctrl_cfg_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
    logic [ctrl_cfg_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
    logic [ctrl_cfg_pkg::FIFO_CNT_BITS-1:0] count;
    logic push;

    assign push = link_in.valid && (count != ctrl_cfg_pkg::FIFO_DEPTH);

    // The dispatcher never stalls, so any stored byte leaves at once.
    assign pop_valid     = (count != '0);
    assign pop_byte      = mem[rd_ptr];
    assign credit_return = pop_valid;   // One credit back in the cycle of each pop.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps since the depth is a power of two.
            end
            if (pop_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= link_in.data;
        end
    end

endmodule

`default_nettype wire

/* rtl/ctrl_types_pkg.sv */
// --------------------------------------------------------------------------
// Words passed between the host link, the dispatcher and the handlers.
// --------------------------------------------------------------------------
`default_nettype none

package ctrl_types_pkg;

    // Host-to-FIFO byte. valid may only be set while the host holds a credit.
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } link_byte_t;

    // Dispatcher-to-handler beat.
    typedef struct packed {
        logic       en;
        logic       last;   // Final payload byte of the command.
        logic [7:0] data;
    } cmd_beat_t;

    // Configuration register bank, register 0 in the low byte.
    typedef struct packed {
        logic [ctrl_cfg_pkg::REG_COUNT-1:0][7:0] regs;
    } cfg_bank_t;

endpackage

`default_nettype wire

/* rtl/ctrl_cfg_pkg.sv */
// --------------------------------------------------------------------------
// Sizes, opcodes and watchdog constants. FIFO_DEPTH and REG_COUNT must be
// powers of two, and LEN_BITS must cover the longest payload.
// --------------------------------------------------------------------------
`default_nettype none

package ctrl_cfg_pkg;

    localparam int FIFO_DEPTH    = 8;                     // Also the host's initial credits.
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

    localparam logic [7:0] OP_WDOG_KICK = 8'hA5;
    localparam logic [7:0] OP_REG_WRITE = 8'h3C;

    localparam int SIG_BITS  = 32;
    localparam int SIG_BYTES = SIG_BITS / 8;
    localparam logic [SIG_BITS-1:0] SIG_PATTERN = 32'hC0DE_F00D;

    localparam int WDOG_TICKS = 200;
    localparam int TICK_BITS  = $clog2(WDOG_TICKS + 1);

    localparam int REG_COUNT     = 8;
    localparam int REG_ADDR_BITS = $clog2(REG_COUNT);

    // Payload length table, indexed by opcode in the dispatcher.
    localparam int LEN_WDOG      = SIG_BYTES;
    localparam int LEN_REG_WRITE = 2;
    localparam int LEN_BITS      = $clog2(LEN_WDOG + 1);   // Watchdog kick is the longest.

endpackage

`default_nettype wire
